// File: logic/pdp8_pkg.sv
package pdp8_pkg;

    typedef logic [0:11] word_t;   // PDP-8 numbering, bit 0 is the MSB
    typedef logic [0:2]  opcode_t;

    // Major states of the processor
    typedef enum logic [4:0] {
        F0, FW, F1, F2, F3,        // Fetch
        D0, DW, D1, D2, D3,        // Defer
        E0, EW, E1, E2, E3,        // Execute
        HW, H1, H2, H3             // Panel deposit/examine
    } major_state_e;

    typedef struct packed {
        logic needs_defer;         // Indirect memory reference
        logic needs_execute;       // AND TAD ISZ DCA JMS
        logic is_jmp_indirect;
        logic is_halt;             // Group 2 with HLT bit
        logic is_ion;
        logic is_iof;
    } instr_class_t;

    typedef struct packed {
        logic cont_pulse;          // One cycle per cont edge
        logic trigger_pulse;       // One cycle per trigger edge
        logic halt_level;
        logic step_level;
    } panel_t;

    // Opcode field, instruction bits 0..2
    localparam opcode_t OP_AND = 3'o0;
    localparam opcode_t OP_TAD = 3'o1;
    localparam opcode_t OP_ISZ = 3'o2;
    localparam opcode_t OP_DCA = 3'o3;
    localparam opcode_t OP_JMS = 3'o4;
    localparam opcode_t OP_JMP = 3'o5;
    localparam opcode_t OP_IOT = 3'o6;
    localparam opcode_t OP_OPR = 3'o7;

    // Processor IOTs for the interrupt system
    localparam word_t IOT_ION = 12'o6001;
    localparam word_t IOT_IOF = 12'o6002;

endpackage

// File: logic/panel_switches.sv
`timescale 1ns/1ps

module panel_switches import pdp8_pkg::*; #(
    parameter int SYNC_STAGES = 2
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   cont_sw,
    input  logic   trigger_sw,
    input  logic   halt_sw,
    input  logic   step_sw,
    output panel_t panel
);

    // Switch vector order is {cont, trigger, halt, step}
    logic [3:0] sync_q [SYNC_STAGES];
    logic [3:0] sw_sync;
    logic [1:0] edge_prev;                  // Last synced cont and trigger
    logic [1:0] edge_pulse;

    assign sw_sync = sync_q[SYNC_STAGES-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= {cont_sw, trigger_sw, halt_sw, step_sw};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];   // Shift toward the output stage
            end
        end
    end

    // Rising edge of cont and trigger gives one strobe each
    always_ff @(posedge clk) begin
        if (reset) begin
            edge_prev  <= '0;
            edge_pulse <= '0;
        end else begin
            edge_prev  <= sw_sync[3:2];
            edge_pulse <= sw_sync[3:2] & ~edge_prev;
        end
    end

    assign panel.cont_pulse    = edge_pulse[1];
    assign panel.trigger_pulse = edge_pulse[0];
    assign panel.halt_level    = sw_sync[1];   // Levels go straight through
    assign panel.step_level    = sw_sync[0];

endmodule

// File: logic/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import pdp8_pkg::*; (
    input  word_t        instruction,
    output instr_class_t iclass
);

    opcode_t opcode;
    logic    indirect;       // Bit 3, also the group select for OPR
    logic    opr_group2;
    logic    hlt_bit;

    assign opcode   = instruction[0:2];
    assign indirect = instruction[3];

    // Group 2 operate has bit 3 set and bit 11 clear
    assign opr_group2 = instruction[3] & ~instruction[11];
    assign hlt_bit    = instruction[10];

    always_comb begin
        iclass = '0;
        case (opcode)
            // Memory reference and JMS all run an execute cycle
            OP_AND,
            OP_TAD,
            OP_ISZ,
            OP_DCA,
            OP_JMS: begin
                iclass.needs_defer   = indirect;
                iclass.needs_execute = 1'b1;
            end

            // JMP direct is done in F3, JMP I ends in D3
            OP_JMP: begin
                iclass.needs_defer     = indirect;
                iclass.is_jmp_indirect = indirect;
            end

            OP_IOT: begin
                iclass.is_ion = (instruction == IOT_ION);
                iclass.is_iof = (instruction == IOT_IOF);
            end

            OP_OPR: begin
                iclass.is_halt = opr_group2 & hlt_bit;   // 7402 and friends
            end
        endcase
    end

endmodule

// File: logic/major_state_seq.sv
`timescale 1ns/1ps

module major_state_seq import pdp8_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         clear,
    input  panel_t       panel,
    input  instr_class_t iclass,
    input  logic         int_req,
    input  logic         int_inh,
    input  logic         int_ena,
    input  logic         user_mode,
    input  logic         autoindex,
    output major_state_e state,
    output logic         run,
    output logic         int_in_prog,
    output logic         instr_done,
    output logic         int_start
);

    logic int_take;          // Interrupt would be granted in F0
    logic fetch_only;
    logic step_hold;         // Single step holding D0 or E0
    logic hlt_stop;

    // IOF in the IR blocks the grant so ION/IOF pairs settle
    assign int_take   = int_req & int_ena & ~int_inh & ~iclass.is_iof;
    assign fetch_only = ~iclass.needs_defer & ~iclass.needs_execute;
    assign step_hold  = panel.step_level & ~panel.cont_pulse;

    // Last cycle of an instruction, the one that returns to F0
    assign instr_done = ((state == F3) && fetch_only) ||
                        ((state == D3) && iclass.is_jmp_indirect) ||
                        (state == E3);

    assign int_start = (state == F0) && run && int_take;

    // HLT only stops the machine outside user mode
    assign hlt_stop = (state == F3) && iclass.is_halt && ~user_mode;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            state       <= F0;
            run         <= 1'b0;
            int_in_prog <= 1'b0;
        end else begin
            if (instr_done && (panel.halt_level || hlt_stop)) begin
                run <= 1'b0;                        // Stop at instruction end
            end

            case (state)
                F0: begin
                    if (!run) begin
                        if (panel.cont_pulse) begin
                            state <= FW;
                            run   <= 1'b1;
                        end else if (panel.trigger_pulse) begin
                            state <= HW;            // Panel cycle while stopped
                        end
                    end else if (int_take) begin
                        state       <= E0;          // Forced JMS to location 0
                        int_in_prog <= 1'b1;
                    end else begin
                        state       <= FW;
                        int_in_prog <= 1'b0;
                    end
                end

                // Fetch
                FW: state <= F1;
                F1: state <= F2;
                F2: state <= F3;
                F3: begin
                    if (iclass.needs_defer) begin
                        state <= D0;
                    end else if (iclass.needs_execute) begin
                        state <= E0;
                    end else begin
                        state <= F0;                // OPR, IOT, JMP direct
                    end
                end

                // Defer
                D0: begin
                    if (!step_hold) begin
                        state <= DW;
                    end
                end
                DW: state <= autoindex ? D1 : D3;   // Locations 10-17 add D1 D2
                D1: state <= D2;
                D2: state <= D3;
                D3: state <= iclass.is_jmp_indirect ? F0 : E0;

                // Execute
                E0: begin
                    if (!step_hold) begin
                        state <= EW;
                    end
                end
                EW: state <= E1;
                E1: state <= E2;
                E2: state <= E3;
                E3: state <= F0;

                // Deposit and examine
                HW: state <= H1;
                H1: state <= H2;
                H2: state <= H3;
                H3: state <= F0;

                default: state <= F0;
            endcase
        end
    end

endmodule

// File: logic/interrupt_ctrl.sv
`timescale 1ns/1ps

module interrupt_ctrl import pdp8_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         clear,
    input  instr_class_t iclass,
    input  logic         instr_done,
    input  logic         int_start,
    output logic         int_ena
);

    // Armed when ION completes, enable follows one instruction later
    logic ion_delay;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            int_ena   <= 1'b0;
            ion_delay <= 1'b0;
        end else if (int_start) begin
            int_ena   <= 1'b0;          // Entry turns the system off
            ion_delay <= 1'b0;
        end else if (instr_done) begin
            if (iclass.is_iof) begin
                int_ena   <= 1'b0;
                ion_delay <= 1'b0;      // IOF also cancels a pending ION
            end else if (iclass.is_ion) begin
                ion_delay <= 1'b1;
            end else if (ion_delay) begin
                int_ena   <= 1'b1;      // Instruction after ION has finished
                ion_delay <= 1'b0;
            end
        end
    end

endmodule

// File: logic/pdp8_control.sv
`timescale 1ns/1ps

module pdp8_control import pdp8_pkg::*; #(
    parameter int SYNC_STAGES = 2
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         clear,
    input  logic         cont_sw,
    input  logic         trigger_sw,
    input  logic         halt_sw,
    input  logic         step_sw,
    input  logic         int_req,
    input  logic         int_inh,
    input  logic         user_mode,
    input  logic         autoindex,
    input  word_t        instruction,
    output major_state_e state,
    output logic         run,
    output logic         int_in_prog,
    output logic         int_ena
);

    panel_t       panel;
    instr_class_t iclass;
    logic         instr_done;
    logic         int_start;

    panel_switches #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_panel (
        .clk        (clk),
        .reset      (reset),
        .cont_sw    (cont_sw),
        .trigger_sw (trigger_sw),
        .halt_sw    (halt_sw),
        .step_sw    (step_sw),
        .panel      (panel)
    );

    instr_decoder u_decoder (
        .instruction (instruction),
        .iclass      (iclass)
    );

    major_state_seq u_seq (
        .clk         (clk),
        .reset       (reset),
        .clear       (clear),
        .panel       (panel),
        .iclass      (iclass),
        .int_req     (int_req),
        .int_inh     (int_inh),
        .int_ena     (int_ena),
        .user_mode   (user_mode),
        .autoindex   (autoindex),
        .state       (state),
        .run         (run),
        .int_in_prog (int_in_prog),
        .instr_done  (instr_done),
        .int_start   (int_start)
    );

    interrupt_ctrl u_int (
        .clk        (clk),
        .reset      (reset),
        .clear      (clear),
        .iclass     (iclass),
        .instr_done (instr_done),
        .int_start  (int_start),
        .int_ena    (int_ena)
    );

endmodule

// File: dv/pdp8_control_assertions.sv
`timescale 1ns/1ps

module pdp8_control_assertions import pdp8_pkg::*; (
    input logic         clk,
    input logic         reset,
    input logic         clear,
    input major_state_e state,
    input logic         run,
    input logic         int_in_prog,
    input logic         instr_done
);

    // Successors of each major state
    function automatic bit next_ok(major_state_e cur, major_state_e nxt);
        case (cur)
            F0:      return nxt inside {F0, FW, E0, HW};
            F3:      return nxt inside {F0, D0, E0};
            D0:      return nxt inside {D0, DW};   // Step may hold
            DW:      return nxt inside {D1, D3};
            D3:      return nxt inside {F0, E0};
            E0:      return nxt inside {E0, EW};
            E3, H3:  return nxt == F0;
            default: return nxt == major_state_e'(cur + 1);   // Straight-line states
        endcase
    endfunction

    a_legal_next: assert property (
        @(posedge clk) disable iff (reset || clear)
        1'b1 |=> next_ok($past(state), state)
    ) else $error("Illegal major state transition into %s", state.name());

    a_run_after_reset: assert property (@(posedge clk) reset |=> !run)
        else $error("run high in the cycle after reset");

    a_int_entry: assert property (
        @(posedge clk) disable iff (reset || clear)
        $rose(int_in_prog) |-> ($past(state) == F0) && (state == E0)
    ) else $error("int_in_prog rose outside an F0 to E0 interrupt entry");

    a_done_strobe: assert property (
        @(posedge clk) disable iff (reset || clear)
        instr_done |=> !instr_done
    ) else $error("instr_done lasted more than one cycle");

endmodule

// File: dv/pdp8_control_tb.sv
`timescale 1ns/1ps

module pdp8_control_tb import pdp8_pkg::*; ();

    localparam int SYNC_STAGES   = 2;
    localparam int CLK_PERIOD_NS = 4;

    localparam word_t NOP   = 12'o7000;
    localparam word_t HLT   = 12'o7402;
    localparam word_t KSF   = 12'o6031;             // Plain IOT, fetch only
    localparam word_t JMP_I = {OP_JMP, 9'o400};
    localparam word_t TAD_D = {OP_TAD, 9'o000};
    localparam word_t DCA_I = {OP_DCA, 9'o400};

    typedef struct packed {
        word_t      instr;
        logic       autoindex;
        logic       user_mode;
        logic       halt;
        logic       int_req;
        logic       int_inh;
        logic       step;
        logic       panel;      // Trigger instead of cont
        logic [4:0] cycles;     // State changes from F0 exit to F0
        logic       run;
        logic       int_in_prog;
        logic       int_ena;
    } test_row_t;

    logic         clk = 1'b0;
    logic         reset, clear, cont_sw, trigger_sw, halt_sw, step_sw;
    logic         int_req, int_inh, user_mode, autoindex;
    word_t        instruction;
    major_state_e state;
    logic         run, int_in_prog, int_ena;

    test_row_t rows[$];
    integer    seed = 32'h22;
    int        error_count = 0;
    int        pass_count = 0;
    bit        table_ready = 1'b0;

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    pdp8_control #(.SYNC_STAGES(SYNC_STAGES)) DUT (.*);

    bind major_state_seq pdp8_control_assertions u_seq_assertions (
        .clk         (clk),
        .reset       (reset),
        .clear       (clear),
        .state       (state),
        .run         (run),
        .int_in_prog (int_in_prog),
        .instr_done  (instr_done)
    );

    task automatic add_row(input word_t instr, input logic ai, um, halt, req, inh, step,
                           input logic panel, input int cycles, input logic r, iip, ena);
        test_row_t row;
        row = '{instr, ai, um, halt, req, inh, step, panel, 5'(cycles), r, iip, ena};
        rows.push_back(row);
    endtask

    // Columns: instruction, autoindex, user_mode, halt_sw, int_req, int_inh, step_sw,
    // panel, cycles, then expected run, int_in_prog, int_ena
    task automatic build_table();
        add_row(NOP,     0, 0, 0, 0, 0, 0, 1,  5, 0, 0, 0);  // HW H1 H2 H3 and back
        add_row(NOP,     0, 0, 0, 0, 0, 0, 0,  5, 1, 0, 0);  // Cont starts the machine
        add_row(KSF,     0, 0, 0, 0, 0, 0, 0,  5, 1, 0, 0);
        add_row(JMP_I,   0, 0, 0, 0, 0, 0, 0,  8, 1, 0, 0);
        add_row(JMP_I,   1, 0, 0, 0, 0, 0, 0, 10, 1, 0, 0);
        add_row(TAD_D,   0, 0, 0, 0, 0, 0, 0, 10, 1, 0, 0);
        add_row(DCA_I,   0, 0, 0, 0, 0, 0, 0, 13, 1, 0, 0);
        add_row(DCA_I,   1, 0, 0, 0, 0, 0, 0, 15, 1, 0, 0);
        add_row(HLT,     0, 1, 0, 0, 0, 0, 0,  5, 1, 0, 0);  // User mode HLT keeps running
        add_row(HLT,     0, 0, 0, 0, 0, 0, 0,  5, 0, 0, 0);
        add_row(NOP,     0, 0, 1, 0, 0, 0, 0,  5, 0, 0, 0);  // Halt switch stops at end
        add_row(IOT_ION, 0, 0, 0, 0, 0, 0, 0,  5, 1, 0, 0);
        add_row(NOP,     0, 0, 0, 0, 0, 0, 0,  5, 1, 0, 1);  // Enable one instr after ION
        add_row(NOP,     0, 0, 0, 1, 1, 0, 0,  5, 1, 0, 1);  // Inhibit blocks entry
        add_row(NOP,     0, 0, 0, 1, 0, 0, 0,  6, 1, 1, 0);  // F0 E0 EW E1 E2 E3 F0
        add_row(IOT_ION, 0, 0, 0, 0, 0, 0, 0,  5, 1, 0, 0);
        add_row(NOP,     0, 0, 0, 0, 0, 0, 0,  5, 1, 0, 1);
        add_row(IOT_IOF, 0, 0, 0, 1, 0, 0, 0,  5, 1, 0, 0);  // IOF wins over the request
        add_row(NOP,     0, 0, 0, 1, 0, 0, 0,  5, 1, 0, 0);
        add_row(TAD_D,   0, 0, 0, 0, 0, 1, 0, 10, 1, 0, 0);  // Step holds E0
        add_row(DCA_I,   0, 0, 0, 0, 0, 1, 0, 13, 1, 0, 0);  // Step holds D0 and E0
        add_row(HLT,     0, 0, 0, 0, 0, 0, 0,  5, 0, 0, 0);
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected) else begin
            $display("Mismatch %s: got %h expected %h", name, got, expected);
            error_count++;
        end
    endtask

    initial begin
        test_row_t    row;
        major_state_e prev;
        major_state_e first;
        int           count;
        int           holds;
        int           waited;
        int           errors_before;
        {reset, clear, cont_sw, trigger_sw, halt_sw, step_sw} = 6'b100000;
        {int_req, int_inh, user_mode, autoindex} = 4'b0000;
        instruction = NOP;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        check_value("state", state, F0);
        check_value("run", run, 0);
        check_value("int_ena", int_ena, 0);
        $display("Reset values checked, %0d errors", error_count);

        foreach (rows[i]) begin
            row = rows[i];
            errors_before = error_count;
            instruction = row.instr;
            if (row.instr[0:2] < OP_IOT) begin
                instruction[4:11] = 8'($random(seed));   // Page bit and offset
            end
            autoindex = row.autoindex;
            user_mode = row.user_mode;
            halt_sw = row.halt;
            int_req = row.int_req;
            int_inh = row.int_inh;
            step_sw = row.step;
            if (row.panel) begin
                trigger_sw = 1'b1;
            end else if (!run) begin
                cont_sw = 1'b1;             // Stopped, press cont
            end
            count = 0;
            holds = 0;
            waited = 0;
            prev = F0;
            first = F0;
            do begin
                @(negedge clk);
                cont_sw = 1'b0;
                trigger_sw = 1'b0;
                if (state != prev) begin
                    count++;
                    waited = 0;
                    if (count == 1) begin
                        first = state;      // State that left F0
                    end
                end else if (state == D0 || state == E0) begin
                    waited++;
                    holds++;
                end
                if (row.step && waited == 1) begin
                    cont_sw = 1'b1;         // Release the step hold
                end
                prev = state;
            end while (state != F0 || count == 0);

            check_value("cycles", count, row.cycles);
            check_value("run", run, row.run);
            check_value("int_in_prog", int_in_prog, row.int_in_prog);
            check_value("int_ena", int_ena, row.int_ena);
            if (row.panel) begin
                check_value("first_state", first, HW);
            end
            assert ((holds != 0) == row.step) else begin
                $display("Test %0d: step hold in D0 or E0 was %s", i,
                         row.step ? "missing" : "not expected");
                error_count++;
            end
            if (error_count == errors_before) begin
                pass_count++;
                $display("Test %0d instr %o: pass, %0d cycles", i, instruction, count);
            end else begin
                $display("Test %0d instr %o: FAIL", i, instruction);
            end
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", rows.size(),
                 pass_count, rows.size() - pass_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int budget;
        wait (table_ready);
        budget = 2;
        foreach (rows[i]) begin
            budget += rows[i].cycles + 2 * (SYNC_STAGES + 2);
        end
        #(budget * CLK_PERIOD_NS * 4);
        $display("Timeout: the sequencer did not get back to F0 within %0d ns",
                 budget * CLK_PERIOD_NS * 4);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: pdp8_control.f
logic/pdp8_pkg.sv
logic/panel_switches.sv
logic/instr_decoder.sv
logic/major_state_seq.sv
logic/interrupt_ctrl.sv
logic/pdp8_control.sv
dv/pdp8_control_assertions.sv
dv/pdp8_control_tb.sv
